//--- Bender.yml
package:
  name: motor_pwm

sources:
  - hdl/motorPkg.sv
  - hdl/frameTimer.sv
  - hdl/stepSequencer.sv
  - hdl/pwmPulseGen.sv
  - hdl/pwmLossMonitor.sv
  - hdl/motorPwmTop.sv
  - target: test
    files:
      - testbench/motorPwm_sva.sv
      - testbench/motorPwmTb.sv

//--- all.f
hdl/motorPkg.sv
hdl/frameTimer.sv
hdl/stepSequencer.sv
hdl/pwmPulseGen.sv
hdl/pwmLossMonitor.sv
hdl/motorPwmTop.sv
testbench/motorPwm_sva.sv
testbench/motorPwmTb.sv

//--- hdl/frameTimer.sv
`timescale 1ns/1ps

module frameTimer #(
    parameter int unsigned FrameLen = 64
) (
    input  logic clk,
    input  logic rst,
    output logic frameFirst,
    output logic frameLast
);

    localparam int CntWidth = (FrameLen > 1) ? $clog2(FrameLen) : 1;
    localparam logic [CntWidth-1:0] CntMax = CntWidth'(FrameLen - 1);

    logic [CntWidth-1:0] count;
    logic [CntWidth-1:0] nextCount;
    logic                running;

    // counter sits at 0 for the first cycle after reset so that frame 0
    // starts right there
    always_comb begin
        if (!running) begin
            nextCount = '0;
        end else if (count == CntMax) begin
            nextCount = '0;
        end else begin
            nextCount = count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running    <= 1'b0;
            count      <= '0;
            frameFirst <= 1'b0;
            frameLast  <= 1'b0;
        end else begin
            running    <= 1'b1;
            count      <= nextCount;
            // strobes decoded from the next count, so they line up with it
            frameFirst <= (nextCount == '0);
            frameLast  <= (nextCount == CntMax);
        end
    end

endmodule

//--- hdl/motorPkg.sv
package motorPkg;

    // width of a pulse-length request and of every on-time count
    localparam int LenWidth = 16;

    // commutation phase, advanced once per consumed command
    typedef enum logic [1:0] {
        phaseA = 2'd0,
        phaseB = 2'd1,
        phaseC = 2'd2
    } phaseT;

    // one-entry command holder state
    typedef enum logic {
        seqEmpty = 1'b0,
        seqFull  = 1'b1
    } seqStateT;

endpackage

//--- hdl/motorPwmTop.sv
`timescale 1ns/1ps

module motorPwmTop import motorPkg::*; #(
    parameter int unsigned FrameLen = 64,
    parameter int unsigned MinPulse = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmdValid,
    input  logic [LenWidth-1:0] cmdLen,
    output logic                cmdReady,
    output logic                pwm,
    output phaseT               phase,
    output logic                statValid,
    output logic [LenWidth-1:0] statWanted,
    output logic [LenWidth-1:0] statReal
);

    logic                frameFirst;
    logic                frameLast;
    logic [LenWidth-1:0] frameLen;

    frameTimer #(
        .FrameLen(FrameLen)
    ) uFrameTimer (
        .clk       (clk),
        .rst       (rst),
        .frameFirst(frameFirst),
        .frameLast (frameLast)
    );

    stepSequencer uStepSequencer (
        .clk      (clk),
        .rst      (rst),
        .frameLast(frameLast),
        .cmdValid (cmdValid),
        .cmdLen   (cmdLen),
        .cmdReady (cmdReady),
        .frameLen (frameLen),
        .phase    (phase)
    );

    pwmPulseGen #(
        .FrameLen(FrameLen),
        .MinPulse(MinPulse)
    ) uPwmPulseGen (
        .clk       (clk),
        .rst       (rst),
        .frameFirst(frameFirst),
        .frameLen  (frameLen),
        .pwm       (pwm)
    );

    // the monitor sees the same request and output as the generator
    pwmLossMonitor uPwmLossMonitor (
        .clk       (clk),
        .rst       (rst),
        .frameFirst(frameFirst),
        .frameLen  (frameLen),
        .pwm       (pwm),
        .statValid (statValid),
        .statWanted(statWanted),
        .statReal  (statReal)
    );

endmodule

//--- hdl/pwmLossMonitor.sv
`timescale 1ns/1ps

module pwmLossMonitor import motorPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                frameFirst,
    input  logic [LenWidth-1:0] frameLen,
    input  logic                pwm,
    output logic                statValid,
    output logic [LenWidth-1:0] statWanted,
    output logic [LenWidth-1:0] statReal
);

    logic [LenWidth-1:0] wantAcc;
    logic [LenWidth-1:0] realAcc;
    logic [LenWidth-1:0] realTotal;
    logic                started;

    // frame cycle 0 still belongs to the window of the frame before
    assign realTotal = realAcc + LenWidth'(pwm);

    always_ff @(posedge clk) begin
        if (rst) begin
            wantAcc   <= '0;
            realAcc   <= '0;
            started   <= 1'b0;
            statValid <= 1'b0;
        end else if (frameFirst) begin
            // no report before one full frame has run
            statValid <= started;
            started   <= 1'b1;
            wantAcc   <= frameLen;
            realAcc   <= '0;
        end else begin
            statValid <= 1'b0;
            realAcc   <= realTotal;
        end
    end

    always_ff @(posedge clk) begin
        if (frameFirst) begin
            statWanted <= wantAcc;
            statReal   <= realTotal;
        end
    end

endmodule

//--- hdl/pwmPulseGen.sv
`timescale 1ns/1ps

module pwmPulseGen import motorPkg::*; #(
    parameter int unsigned FrameLen = 64,
    parameter int unsigned MinPulse = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                frameFirst,
    input  logic [LenWidth-1:0] frameLen,
    output logic                pwm
);

    localparam logic [LenWidth-1:0] FullLen = LenWidth'(FrameLen);
    localparam logic [LenWidth-1:0] MinLen  = LenWidth'(MinPulse);

    logic [LenWidth-1:0] carry;
    logic [LenWidth-1:0] sum;
    logic                loadPulse;
    logic [LenWidth-1:0] onTime;
    logic [LenWidth-1:0] nextCarry;
    logic [LenWidth-1:0] onCnt;

    // request for this frame plus whatever was left over before
    assign sum = carry + frameLen;

    // too short for the power switches, keep it for the next frame
    assign loadPulse = (sum >= MinLen);

    always_comb begin
        if (!loadPulse) begin
            onTime    = '0;
            nextCarry = sum;
        end else if (sum > FullLen) begin
            // clip to one frame, the excess rolls over
            onTime    = FullLen;
            nextCarry = sum - FullLen;
        end else begin
            onTime    = sum;
            nextCarry = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            carry <= '0;
        end else if (frameFirst) begin
            carry <= nextCarry;
        end
    end

    // on-time counter loaded in frame cycle 0, so the pulse starts in cycle 1
    // and a full-frame pulse runs into cycle 0 of the next frame
    always_ff @(posedge clk) begin
        if (rst) begin
            onCnt <= '0;
        end else if (frameFirst) begin
            onCnt <= onTime;
        end else if (onCnt != '0) begin
            onCnt <= onCnt - 1'b1;
        end
    end

    assign pwm = (onCnt != '0);

endmodule

//--- hdl/stepSequencer.sv
`timescale 1ns/1ps

module stepSequencer import motorPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                frameLast,
    input  logic                cmdValid,
    input  logic [LenWidth-1:0] cmdLen,
    output logic                cmdReady,
    output logic [LenWidth-1:0] frameLen,
    output phaseT               phase
);

    seqStateT            state;
    logic [LenWidth-1:0] holdLen;
    logic                take;
    logic                consume;
    logic [LenWidth-1:0] nextLen;

    // commutation order A -> B -> C -> A
    function automatic phaseT nextPhase(input phaseT cur);
        phaseT nxt;
        case (cur)
            phaseA:  nxt = phaseB;
            phaseB:  nxt = phaseC;
            default: nxt = phaseA;
        endcase
        return nxt;
    endfunction

    assign cmdReady = (state == seqEmpty);
    assign take     = cmdValid && cmdReady;

    // a transfer in the frameLast cycle goes straight to the next frame
    assign consume = (state == seqFull) || take;
    assign nextLen = (state == seqFull) ? holdLen : cmdLen;

    always_ff @(posedge clk) begin
        if (take) begin
            holdLen <= cmdLen;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= seqEmpty;
            frameLen <= '0;
            phase    <= phaseA;
        end else if (frameLast) begin
            state <= seqEmpty;
            if (consume) begin
                frameLen <= nextLen;
                phase    <= nextPhase(phase);
            end else begin
                // nothing held, so the coming frame is idle
                frameLen <= '0;
            end
        end else if (take) begin
            state <= seqFull;
        end
    end

endmodule

//--- testbench/motorPwmTb.sv
`timescale 1ns/1ps

module motorPwmTb import motorPkg::*; ();

    localparam int FrameLen    = 64;
    localparam int MinPulse    = 8;
    localparam int ClkPeriod   = 4;
    localparam int NumFrames   = 300;
    localparam int DrainFrames = 6;
    localparam int WatchdogNs  = 400 * FrameLen * ClkPeriod + 2000;

    // index of each test in the error counters
    localparam int TestHs     = 0;
    localparam int TestWidth  = 1;
    localparam int TestClip   = 2;
    localparam int TestPhase  = 3;
    localparam int TestReport = 4;

    logic                clk;
    logic                rst;
    logic                cmdValid;
    logic [LenWidth-1:0] cmdLen;
    logic                cmdReady;
    logic                pwm;
    phaseT               phase;
    logic                statValid;
    logic [LenWidth-1:0] statWanted;
    logic [LenWidth-1:0] statReal;

    // model, one entry per frame
    int    reqOf  [0:NumFrames];
    int    onOf   [0:NumFrames];
    bit    usedOf [0:NumFrames];
    bit    clipOf [0:NumFrames];
    int    nErr   [0:4];
    string testName [0:4] = '{"handshake", "pulse width", "clipping", "phase", "loss report"};

    int    carry = 0;
    bit    clipCarry = 0;
    int    highCnt = 0;
    int    gapLeft = 0;
    bit    dropValid = 0;
    bit    gotThisFrame = 0;
    int    gotLen = 0;
    int    transfers = 0;
    int    phaseSteps = 0;
    int    clipFrames = 0;
    int    shortCarries = 0;
    int    totalErr = 0;
    int    failedTests = 0;
    phaseT modelPhase = phaseA;
    phaseT lastPhase = phaseA;

    initial clk = 1'b0;
    always #(ClkPeriod / 2) clk = ~clk;

    motorPwmTop #(
        .FrameLen(FrameLen),
        .MinPulse(MinPulse)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .cmdValid  (cmdValid),
        .cmdLen    (cmdLen),
        .cmdReady  (cmdReady),
        .pwm       (pwm),
        .phase     (phase),
        .statValid (statValid),
        .statWanted(statWanted),
        .statReal  (statReal)
    );

    task automatic flagMismatch(input int test, input string name, input int got, input int exp);
        nErr[test]++;
        $display("[ERROR] %0t ns %s: got %0d expected %0d", $time, name, got, exp);
    endtask

    function automatic phaseT rotate(input phaseT p);
        if (p == phaseA) begin
            return phaseB;
        end
        return (p == phaseB) ? phaseC : phaseA;
    endfunction

    // carry of short requests, clipping to one frame, phase step per command
    task automatic startFrame(input int f);
        int sum;
        sum = carry + reqOf[f];
        clipOf[f] = clipCarry;
        clipCarry = 1'b0;
        if (sum < MinPulse) begin
            onOf[f] = 0;
            carry = sum;
            shortCarries += (reqOf[f] > 0);
        end else if (sum > FrameLen) begin
            onOf[f] = FrameLen;
            carry = sum - FrameLen;
            clipOf[f] = 1'b1;
            clipCarry = 1'b1;
            clipFrames++;
        end else begin
            onOf[f] = sum;
            carry = 0;
        end
        if (usedOf[f]) begin
            modelPhase = rotate(modelPhase);
        end
    endtask

    task automatic checkOutputs(input int f, input int fc);
        bit expValid;
        // a frame's pwm window ends with cycle 0 of the next frame
        highCnt += pwm;
        if (fc == 0) begin
            if (f > 0 && highCnt != onOf[f-1]) begin
                flagMismatch(clipOf[f-1] ? TestClip : TestWidth, "pwm high cycles",
                             highCnt, onOf[f-1]);
            end
            highCnt = 0;
            startFrame(f);
        end
        if (phase != modelPhase) begin
            flagMismatch(TestPhase, "phase", int'(phase), int'(modelPhase));
        end
        phaseSteps += (phase != lastPhase);
        lastPhase = phase;
        expValid = (fc == 1 && f > 0);
        if (statValid != expValid) begin
            flagMismatch(TestReport, "statValid", statValid, expValid);
        end
        if (expValid && statWanted != reqOf[f-1]) begin
            flagMismatch(TestReport, "statWanted", statWanted, reqOf[f-1]);
        end
        if (expValid && statReal != onOf[f-1]) begin
            flagMismatch(TestReport, "statReal", statReal, onOf[f-1]);
        end
        if (cmdReady != !gotThisFrame) begin
            flagMismatch(TestHs, "cmdReady", cmdReady, !gotThisFrame);
        end
    endtask

    task automatic driveCommand(input int f, input int fc);
        if (dropValid) begin
            cmdValid = 1'b0;
            gapLeft = $urandom_range(0, 150);
        end
        if (!cmdValid && gapLeft > 0) begin
            gapLeft--;
        end else if (!cmdValid && f < NumFrames - DrainFrames) begin
            cmdValid = 1'b1;
            cmdLen = LenWidth'($urandom_range(0, 100));
        end
        // a transfer at the coming edge feeds the next frame
        dropValid = cmdValid && cmdReady;
        if (dropValid) begin
            transfers++;
            gotThisFrame = 1'b1;
            gotLen = cmdLen;
        end
        if (fc == FrameLen - 1) begin
            reqOf[f+1] = gotThisFrame ? gotLen : 0;
            usedOf[f+1] = gotThisFrame;
            gotThisFrame = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(28005));
        rst = 1'b1;
        cmdValid = 1'b0;
        cmdLen = '0;
        for (int i = 0; i <= NumFrames; i++) begin
            reqOf[i] = 0;
            usedOf[i] = 1'b0;
        end
        for (int t = 0; t < 5; t++) begin
            nErr[t] = 0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int k = 0; k < NumFrames * FrameLen; k++) begin
            @(negedge clk);
            checkOutputs(k / FrameLen, k % FrameLen);
            driveCommand(k / FrameLen, k % FrameLen);
        end
        // every accepted command moves the phase exactly once
        if (phaseSteps != transfers) begin
            $display("%0d commands were accepted but %0d were consumed", transfers, phaseSteps);
            nErr[TestHs]++;
        end
        if (clipFrames == 0) begin
            $display("no frame with a request above the frame length was run");
            nErr[TestClip]++;
        end
        if (shortCarries == 0) begin
            $display("no request below the minimum pulse was carried over");
            nErr[TestWidth]++;
        end
        for (int t = 0; t < 5; t++) begin
            $display("test %s done with %0d errors", testName[t], nErr[t]);
            totalErr += nErr[t];
            failedTests += (nErr[t] > 0);
        end
        $display("5 tests, %0d failed, %0d errors, %0d commands", failedTests, totalErr,
                 transfers);
        if (totalErr == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(WatchdogNs);
        $display("timeout, the run did not end within %0d ns", WatchdogNs);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- testbench/motorPwm_sva.sv
`timescale 1ns/1ps

module motorPwmSva import motorPkg::*; (
    input logic                clk,
    input logic                rst,
    input logic                cmdValid,
    input logic [LenWidth-1:0] cmdLen,
    input logic                cmdReady,
    input logic                pwm,
    input logic                statValid
);

    // a stalled command keeps its length
    property lenStable;
        @(posedge clk) disable iff (rst) (cmdValid && !cmdReady) |=> $stable(cmdLen);
    endproperty

    property strobeSingle;
        @(posedge clk) disable iff (rst) statValid |=> !statValid;
    endproperty

    // pwm is registered, clean from the second reset cycle on
    property pwmLowInReset;
        @(posedge clk) (rst && $past(rst)) |-> !pwm;
    endproperty

    assert property (lenStable) else $error("cmdLen changed while stalled");
    assert property (strobeSingle) else $error("statValid high for two cycles");
    assert property (pwmLowInReset) else $error("pwm high during reset");

endmodule

bind motorPwmTop motorPwmSva pwmChecks (.*);
